// ==== rtl/conv_params.svh ====
//##########################################################
// sizing macros of the convolution datapath
// kernel width, operand widths and user flag bit positions
//##########################################################

`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// one datapath per kernel column
`define CONV_KW           3                  // kernel width and number of datapaths

// operand and result widths
`define CONV_PIX_W        8                  // signed pixel width
`define CONV_WGT_W        8                  // signed weight width
`define CONV_SUM_W        32                 // accumulator and output width

// user flags that travel with every beat
`define CONV_USER_W       3                  // width of the flag vector
`define CONV_U_1X1        0                  // 1x1 mode, datapath 0 goes straight out
`define CONV_U_RELU       1                  // clamp negative results to zero
`define CONV_U_BLOCK_LAST 2                  // last column of an image row, carries restart

`endif

// ==== rtl/conv_pkg.sv ====
//##########################################################
// shared types of the convolution engine
// scalar typedefs and the beat structs passed between stages
//##########################################################

`include "conv_params.svh"

package conv_pkg;

    //##########################################################
    // scalar types
    //##########################################################

    typedef logic signed [`CONV_PIX_W-1:0]             pixel_t;    // one input pixel
    typedef logic signed [`CONV_WGT_W-1:0]             weight_t;   // one kernel weight
    typedef logic signed [`CONV_PIX_W+`CONV_WGT_W-1:0] product_t;  // full width pixel x weight
    typedef logic signed [`CONV_SUM_W-1:0]             sum_t;      // accumulator and output word
    typedef logic        [`CONV_USER_W-1:0]            user_t;     // per column user flags

    //##########################################################
    // beats between pipeline stages
    //##########################################################

    typedef struct packed {
        pixel_t                    pixel;    // pixel of the current input channel
        weight_t [`CONV_KW-1:0]    weights;  // one weight per datapath, index 0 is leftmost
        logic                      last;     // closes the column
        user_t                     user;     // flags of the column
    } in_beat_t;

    typedef struct packed {
        logic                      valid;    // products hold a real beat
        product_t [`CONV_KW-1:0]   product;  // pixel times each weight
        logic                      last;     // column end travels along
        user_t                     user;
    } prod_beat_t;

    typedef struct packed {
        logic                      valid;    // high only for a completed column
        sum_t [`CONV_KW-1:0]       sum;      // channel sums of each datapath
        user_t                     user;
    } col_sum_t;

    typedef struct packed {
        logic                      valid;    // one output column
        sum_t                      data;
        user_t                     user;
    } out_beat_t;

endpackage

// ==== rtl/mul_stage.sv ====
//##########################################################
// multiply stage of the convolution unit
// registers the accepted beat and one product per datapath
//##########################################################

`timescale 1ns/1ns

`include "conv_params.svh"

module mul_stage (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 advance,    // global pipeline enable
    input  logic                 s_valid,    // beat present at the input
    input  conv_pkg::in_beat_t   s_beat,
    output conv_pkg::prod_beat_t prod
);

    logic                              valid_q;    // a beat sits in the product register
    logic                              last_q;     // beat closed its column
    conv_pkg::user_t                   user_q;     // flags carried with the beat
    conv_pkg::product_t [`CONV_KW-1:0] product_q;  // registered multiplier bank

    //##########################################################
    // control
    //##########################################################

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;                 // empty pipeline after reset
        end else if (advance) begin
            valid_q <= s_valid;              // a gap on the input becomes a bubble here
        end
    end

    //##########################################################
    // multiplier bank
    //##########################################################

    always_ff @(posedge aclk) begin
        if (advance && s_valid) begin                   // payload only moves with a real beat
            last_q <= s_beat.last;
            user_q <= s_beat.user;
            for (int i = 0; i < `CONV_KW; i++) begin
                // the same pixel meets every weight of the kernel row
                product_q[i] <= $signed(s_beat.pixel) * $signed(s_beat.weights[i]);
            end
        end
    end

    assign prod = '{valid: valid_q, product: product_q, last: last_q, user: user_q};

endmodule

// ==== rtl/acc_stage.sv ====
//##########################################################
// channel accumulators of the convolution unit
// one running sum per datapath, emitted at each column end
//##########################################################

`timescale 1ns/1ns

`include "conv_params.svh"

module acc_stage (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 advance,   // global pipeline enable
    input  conv_pkg::prod_beat_t prod,      // products from the multiply stage
    output conv_pkg::col_sum_t   col        // completed column sums
);

    logic                          closed_q;     // previous valid beat ended a column
    logic                          col_valid_q;  // sums below are a finished column
    conv_pkg::user_t               user_q;       // flags of the finished column
    conv_pkg::sum_t [`CONV_KW-1:0] acc_q;        // running channel sums
    conv_pkg::sum_t [`CONV_KW-1:0] acc_next;     // sums after adding the current products

    //##########################################################
    // accumulate
    //##########################################################

    always_comb begin
        for (int i = 0; i < `CONV_KW; i++) begin
            // a new column starts from zero instead of the old total
            acc_next[i] = (closed_q ? '0 : acc_q[i])
                        + conv_pkg::sum_t'($signed(prod.product[i]));
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            acc_q       <= '0;                          // accumulators start at zero
            closed_q    <= 1'b0;
            col_valid_q <= 1'b0;
        end else if (advance) begin
            col_valid_q <= prod.valid && prod.last;     // exactly one advanced cycle per column
            if (prod.valid) begin
                acc_q    <= acc_next;
                closed_q <= prod.last;                  // next beat will restart the sums
            end
        end
    end

    // the flags only matter on the column that is presented
    always_ff @(posedge aclk) begin
        if (advance && prod.valid && prod.last) begin
            user_q <= prod.user;
        end
    end

    assign col = '{valid: col_valid_q, sum: acc_q, user: user_q};

endmodule

// ==== rtl/conv_unit.sv ====
//##########################################################
// convolution unit with multiply and accumulate stages
// snaking carries build the horizontal sum of each column
//##########################################################

`timescale 1ns/1ns

`include "conv_params.svh"

module conv_unit (
    input  logic                aclk,
    input  logic                rst,
    input  logic                advance,    // global pipeline enable
    input  logic                s_valid,
    input  conv_pkg::in_beat_t  s_beat,
    output conv_pkg::out_beat_t unit_col    // full column result before relu
);

    conv_pkg::prod_beat_t          prod;         // multiply stage to accumulators
    conv_pkg::col_sum_t            col;          // column sums of all datapaths
    conv_pkg::sum_t [`CONV_KW-2:0] carry_q;      // partial sums snaking to the right
    logic                          is_1x1;       // column skips the snake
    logic                          restart;      // carries clear after this column
    logic                          out_valid_q;
    conv_pkg::sum_t                out_data_q;
    conv_pkg::user_t               out_user_q;

    assign is_1x1  = col.user[`CONV_U_1X1];
    assign restart = is_1x1 || col.user[`CONV_U_BLOCK_LAST];    // 1x1 also breaks the row

    mul_stage mul_stage_i (
        .aclk    (aclk),
        .rst     (rst),
        .advance (advance),
        .s_valid (s_valid),
        .s_beat  (s_beat),
        .prod    (prod)
    );

    acc_stage acc_stage_i (
        .aclk    (aclk),
        .rst     (rst),
        .advance (advance),
        .prod    (prod),
        .col     (col)
    );

    //##########################################################
    // snake carries, left to right
    //##########################################################

    always_ff @(posedge aclk) begin
        if (rst) begin
            carry_q     <= '0;                          // no earlier columns count
            out_valid_q <= 1'b0;
        end else if (advance) begin
            out_valid_q <= col.valid;
            if (col.valid) begin
                if (restart) begin
                    carry_q <= '0;                      // the output below still used the old carries
                end else begin
                    carry_q[0] <= col.sum[0];           // leftmost datapath has nothing to its left
                    for (int i = 1; i < `CONV_KW - 1; i++) begin
                        carry_q[i] <= col.sum[i] + carry_q[i-1];
                    end
                end
            end
        end
    end

    // rightmost datapath closes the kernel with everything carried so far
    always_ff @(posedge aclk) begin
        if (advance && col.valid) begin
            out_user_q <= col.user;
            out_data_q <= is_1x1 ? col.sum[0] : col.sum[`CONV_KW-1] + carry_q[`CONV_KW-2];
        end
    end

    assign unit_col = '{valid: out_valid_q, data: out_data_q, user: out_user_q};

endmodule

// ==== rtl/conv_out.sv ====
//##########################################################
// output register of the convolution engine
// relu, back-pressure hold and the pipeline advance enable
//##########################################################

`timescale 1ns/1ns

`include "conv_params.svh"

module conv_out (
    input  logic                aclk,
    input  logic                rst,
    input  conv_pkg::out_beat_t unit_col,  // column from the convolution unit
    output logic                advance,   // moves every stage of the pipeline
    output logic                m_valid,
    output conv_pkg::sum_t      m_data,
    output conv_pkg::user_t     m_user,
    input  logic                m_ready
);

    logic            valid_q;     // output register holds a column
    conv_pkg::sum_t  data_q;
    conv_pkg::user_t user_q;
    conv_pkg::sum_t  relu_data;   // column after the optional clamp

    assign advance = !valid_q || m_ready;               // stalls only when a held column is refused

    // a set sign bit means negative
    assign relu_data = (unit_col.user[`CONV_U_RELU] && unit_col.data[`CONV_SUM_W-1]) ?
                       '0 : unit_col.data;

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= unit_col.valid;                  // drains as the consumer takes it
        end
    end

    always_ff @(posedge aclk) begin
        if (advance && unit_col.valid) begin            // held stable while stalled
            data_q <= relu_data;
            user_q <= unit_col.user;
        end
    end

    assign m_valid = valid_q;
    assign m_data  = data_q;
    assign m_user  = user_q;

endmodule

// ==== rtl/conv_engine.sv ====
//##########################################################
// top level of the convolution engine
// convolution unit and output register on the two streams
//##########################################################

`timescale 1ns/1ns

module conv_engine (
    input  logic                aclk,
    input  logic                rst,

    // input stream, one pixel and one kernel row per beat
    input  logic                s_valid,
    input  conv_pkg::in_beat_t  s_beat,
    output logic                s_ready,

    // output stream, one word per column
    output logic                m_valid,
    output conv_pkg::sum_t      m_data,
    output conv_pkg::user_t     m_user,
    input  logic                m_ready
);

    logic                advance;     // shared enable of all stages
    conv_pkg::out_beat_t unit_col;    // column result before relu

    conv_unit conv_unit_i (
        .aclk     (aclk),
        .rst      (rst),
        .advance  (advance),
        .s_valid  (s_valid),
        .s_beat   (s_beat),
        .unit_col (unit_col)
    );

    conv_out conv_out_i (
        .aclk     (aclk),
        .rst      (rst),
        .unit_col (unit_col),
        .advance  (advance),
        .m_valid  (m_valid),
        .m_data   (m_data),
        .m_user   (m_user),
        .m_ready  (m_ready)
    );

    assign s_ready = advance;         // a beat enters whenever the pipeline moves

endmodule

// ==== tests/tb_conv_engine.sv ====
//##########################################################
// testbench of the convolution engine
// column stimulus, reference model, output checker, watchdog
//##########################################################

`timescale 1ns/1ns

`include "conv_params.svh"

module tb_conv_engine;

    typedef conv_pkg::sum_t [`CONV_KW-1:0] sum_row_t;    // channel sums of one column

    logic                aclk = 1'b0;
    logic                rst;
    logic                s_valid;
    conv_pkg::in_beat_t  s_beat;
    logic                s_ready;
    logic                m_valid;
    conv_pkg::sum_t      m_data;
    conv_pkg::user_t     m_user;
    logic                m_ready;

    integer              seed = 22984;     // one stream of random numbers for the whole run
    conv_pkg::in_beat_t  beats[$];         // every beat of every test, in order
    sum_row_t            col_sums[$];      // S_i of each column
    conv_pkg::user_t     col_users[$];
    conv_pkg::sum_t      exp_data[$];      // expected outputs, oldest first
    conv_pkg::user_t     exp_user[$];
    int                  accept_cycle[$];  // cycle at which each last beat went in
    string               test_name[$];
    int                  test_beat_end[$]; // beat count when the test closes
    int                  test_col_end[$];
    int                  test_gap[$];      // percent of cycles with s_valid low
    int                  test_stall[$];    // percent of cycles with m_ready low
    bit                  test_lat[$];
    int                  cycle = 0;
    int                  received = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  modelled = 0;     // columns already run through the reference
    int                  block_start = 0;  // oldest column the snake may reach back to
    bit                  check_latency = 1'b0;
    bit                  gen_done = 1'b0;

    conv_engine conv_engine_i (
        .aclk    (aclk),
        .rst     (rst),
        .s_valid (s_valid),
        .s_beat  (s_beat),
        .s_ready (s_ready),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_user  (m_user),
        .m_ready (m_ready)
    );

    always #2 aclk = ~aclk;                // 4 ns period
    always @(posedge aclk) cycle <= cycle + 1;

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic int rand_pct();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    function automatic conv_pkg::user_t user_flags(input bit one, input bit relu, input bit blk);
        conv_pkg::user_t u;
        u = '0;
        u[`CONV_U_1X1]        = one;
        u[`CONV_U_RELU]       = relu;
        u[`CONV_U_BLOCK_LAST] = blk;
        return u;
    endfunction

    //##########################################################
    // stimulus and reference model
    //##########################################################

    // one column of 1 to 6 input channels where negative forces every product below zero
    task automatic make_column(input conv_pkg::user_t user, input bit negative);
        conv_pkg::in_beat_t b;
        sum_row_t           s;
        int                 n_ch;
        n_ch = 1 + int'(rand_byte() % 6);
        s = '0;
        for (int c = 0; c < n_ch; c++) begin
            b.pixel = rand_byte();
            for (int i = 0; i < `CONV_KW; i++) begin
                b.weights[i] = rand_byte();
                if (negative) b.weights[i][7] = 1'b1;   // a set sign bit makes the weight negative
            end
            if (negative) b.pixel = {1'b0, b.pixel[6:0]} | 8'd1;    // strictly positive
            b.last = (c == n_ch - 1);
            b.user = user;
            for (int i = 0; i < `CONV_KW; i++) begin
                s[i] += conv_pkg::sum_t'(b.pixel) * conv_pkg::sum_t'(b.weights[i]);
            end
            beats.push_back(b);
        end
        col_sums.push_back(s);
        col_users.push_back(user);
    endtask

    task automatic mark_test_end(input string name, input int gap, input int stall, input bit lat);
        test_name.push_back(name);
        test_beat_end.push_back(beats.size());
        test_col_end.push_back(col_sums.size());
        test_gap.push_back(gap);
        test_stall.push_back(stall);
        test_lat.push_back(lat);
    endtask

    // output g is S_2(g) + S_1(g-1) + S_0(g-2) where columns before a restart count as zero
    function automatic void reference_model();
        conv_pkg::sum_t  e;
        conv_pkg::user_t u;
        int              g;
        while (modelled < col_sums.size()) begin
            g = modelled;
            u = col_users[g];
            e = '0;
            if (u[`CONV_U_1X1]) begin
                e = col_sums[g][0];                     // datapath 0 alone
            end else begin
                for (int k = 0; k < `CONV_KW; k++) begin
                    if (g - k >= block_start) e += col_sums[g-k][`CONV_KW-1-k];
                end
            end
            if (u[`CONV_U_RELU] && e < 0) e = '0;
            if (u[`CONV_U_1X1] || u[`CONV_U_BLOCK_LAST]) block_start = g + 1;
            exp_data.push_back(e);
            exp_user.push_back(u);
            modelled++;
        end
    endfunction

    // drives one test's beats and m_ready until all its columns came out
    task automatic run_stream(input int t);
        int idx;
        idx = (t == 0) ? 0 : test_beat_end[t-1];
        while (idx < test_beat_end[t] || received < test_col_end[t]) begin
            @(posedge aclk);
            if (s_valid && s_ready) begin
                if (s_beat.last) accept_cycle.push_back(cycle);
                idx++;
            end
            m_ready <= (test_stall[t] == 0) || (rand_pct() >= test_stall[t]);
            if (!s_valid || s_ready) begin                  // a refused beat stays on the bus
                if (idx < test_beat_end[t] && rand_pct() >= test_gap[t]) begin
                    s_valid <= 1'b1;
                    s_beat  <= beats[idx];
                end else begin
                    s_valid <= 1'b0;
                end
            end
        end
    endtask

    //##########################################################
    // output checker and watchdog
    //##########################################################

    always @(posedge aclk) begin
        if (!rst && m_valid && m_ready) begin
            assert (exp_data.size() != 0) else begin
                $display("an output word arrived at %0t ns with no column left to expect",
                         $time);
                errors++;
            end
            if (exp_data.size() != 0) begin
                checks++;
                assert (m_data == exp_data[0] && m_user == exp_user[0]) else begin
                    $display("[FAIL] %0t ns: column %0d gave %0d flags %b, expected %0d flags %b",
                             $time, received, m_data, m_user, exp_data[0], exp_user[0]);
                    errors++;
                end
                if (check_latency) begin
                    assert (cycle - accept_cycle[0] == 4) else begin
                        $display("[FAIL] %0t ns: column %0d took %0d cycles instead of 4",
                                 $time, received, cycle - accept_cycle[0]);
                        errors++;
                    end
                end
                void'(exp_data.pop_front());
                void'(exp_user.pop_front());
                void'(accept_cycle.pop_front());
                received++;
            end
        end
    end

    initial begin
        wait (gen_done);
        repeat ((beats.size() + col_sums.size()) * 20) @(posedge aclk);
        $display("timeout: the output stream stopped before every column came out");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int errs_before;
        int failed;
        rst     = 1'b1;
        s_valid = 1'b0;
        s_beat  = '0;
        m_ready = 1'b0;
        failed  = 0;
        for (int c = 0; c < 8; c++) make_column(user_flags(1, 0, 0), 0);
        mark_test_end("1x1 columns", 0, 0, 0);
        for (int c = 0; c < 10; c++) make_column(user_flags(0, 0, c == 9), 0);
        mark_test_end("snake sum across a block", 0, 0, 0);
        for (int c = 0; c < 7; c++) make_column(user_flags(0, 0, c == 2 || c == 6), 0);
        mark_test_end("block end clears carries", 0, 0, 0);
        for (int c = 0; c < 8; c++) make_column(user_flags(0, c % 2, c == 7), 1);
        mark_test_end("relu on negative sums", 0, 0, 0);
        for (int c = 0; c < 20; c++) begin
            make_column(user_flags(rand_pct() < 25, rand_pct() < 50, rand_pct() < 20), 0);
        end
        mark_test_end("random gaps and back-pressure", 30, 40, 0);
        for (int c = 0; c < 8; c++) make_column(user_flags(0, 0, 0), 0);
        mark_test_end("latency of four cycles", 0, 0, 1);
        reference_model();
        gen_done = 1'b1;

        repeat (8) @(posedge aclk);
        rst <= 1'b0;
        for (int t = 0; t < test_name.size(); t++) begin
            errs_before   = errors;
            check_latency = test_lat[t];
            run_stream(t);
            $display("test %0d %s: %0d errors", t + 1, test_name[t], errors - errs_before);
            if (errors != errs_before) failed++;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_name.size(), failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/mul_stage.sv
rtl/acc_stage.sv
rtl/conv_unit.sv
rtl/conv_out.sv
rtl/conv_engine.sv
tests/tb_conv_engine.sv

// ==== Makefile ====
# Verilator simulation of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_engine
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
